// ==== src/fdd_pkg.sv ====
package fdd_pkg;

   // board types on the expansion bus.
   typedef enum logic [7:0] {
      DEV_NONE   = 8'h00,
      DEV_VY0010 = 8'h10,
      DEV_RAM    = 8'h20,
      DEV_PRINT  = 8'h30
   } dev_typ_e;

   typedef struct packed {
      dev_typ_e   typ;
      logic [3:0] num;
   } device_sel_t;

   typedef struct packed {
      logic [13:0] addr;
      logic [7:0]  data;
      logic        rd;
      logic        wr;
   } cpu_req_t;

   // mounted is a single-cycle pulse from the SD host.
   typedef struct packed {
      logic        mounted;
      logic        readonly;
      logic [31:0] size;
   } image_info_t;

   typedef struct packed {
      logic [31:0] lba;
      logic        rd;
      logic        wr;
      logic [7:0]  buff_data;
   } sd_req_t;

   typedef struct packed {
      logic       ack;
      logic [8:0] buff_addr;
      logic [7:0] buff_data;
      logic       buff_wr;
   } sd_rsp_t;

   typedef struct packed {
      logic [1:0] addr;
      logic       cmd_wr;
      logic       track_wr;
      logic       sector_wr;
      logic       data_wr;
      logic       data_rd;
      logic       status_rd;
      logic [7:0] wdata;
   } fdc_reg_acc_t;

   typedef enum logic [1:0] {
      CMD_RESTORE,
      CMD_SEEK,
      CMD_READ,
      CMD_WRITE
   } fdc_cmd_e;

   // type1 view after restore and seek, type2 view after read and write.
   typedef union packed {
      struct packed {
         logic not_ready;
         logic wprot;
         logic head_loaded;
         logic seek_err;
         logic crc_err;
         logic track0;
         logic index;
         logic busy;
      } type1;
      struct packed {
         logic not_ready;
         logic wprot;
         logic rec_type;
         logic rnf;
         logic crc_err;
         logic lost_data;
         logic drq;
         logic busy;
      } type2;
   } fdc_status_u;

   localparam int unsigned SECTORS_PER_TRACK = 9;
   localparam int unsigned TRACK_COUNT       = 80;
   localparam int unsigned SECTOR_BYTES      = 512;
   localparam logic [31:0] SINGLE_SIDE_LIMIT = 32'h0005_A000;

   localparam logic [13:0] WD_BASE_ADDR   = 14'h3FF8;
   localparam logic [13:0] SIDE_REG_ADDR  = 14'h3FFC;
   localparam logic [13:0] DRIVE_REG_ADDR = 14'h3FFD;
   localparam logic [13:0] UNUSED_ADDR    = 14'h3FFE;
   localparam logic [13:0] STATUS_ADDR    = 14'h3FFF;

endpackage

// ==== src/fdc_sector_buffer.sv ====
`timescale 1ns/10ps

module fdc_sector_buffer (
   input  logic             cpu_bus,
   input  logic [8:0]       buf_addr,
   input  logic [7:0]       buf_wdata,
   input  logic             buf_we,
   input  fdd_pkg::sd_rsp_t sd_rsp,
   output logic [7:0]       buf_rdata,
   output logic [7:0]       sd_rdata
);
   import fdd_pkg::*;

   logic [7:0] mem [SECTOR_BYTES];

   // one write port shared by the SD host and the CPU side.
   always_ff @(posedge cpu_bus) begin
      if (sd_rsp.buff_wr)
         mem[sd_rsp.buff_addr] <= sd_rsp.buff_data;
      else if (buf_we)
         mem[buf_addr] <= buf_wdata;
   end

   // SD host takes write-back data one cycle after the address.
   always_ff @(posedge cpu_bus) begin
      sd_rdata <= mem[sd_rsp.buff_addr];
   end

   assign buf_rdata = mem[buf_addr];

   assert property (@(posedge cpu_bus) !(buf_we && sd_rsp.buff_wr));

endmodule

// ==== src/fdc_image_geometry.sv ====
`timescale 1ns/10ps

module fdc_image_geometry (
   input  logic                 cpu_bus,
   input  logic                 rst,
   input  fdd_pkg::image_info_t image_info,
   input  logic [7:0]           track,
   input  logic [7:0]           sector,
   input  logic                 side,
   output logic                 mounted,
   output logic                 readonly,
   output logic [31:0]          lba,
   output logic                 rec_ok
);
   import fdd_pkg::*;

   logic        double_sided;
   logic [31:0] image_size;
   logic [31:0] track_index;

   always_ff @(posedge cpu_bus) begin
      if (rst) begin
         mounted      <= 1'b0;
         readonly     <= 1'b0;
         double_sided <= 1'b0;
      end else if (image_info.mounted) begin
         // an empty image counts as no disk.
         mounted      <= (image_info.size != 32'd0);
         readonly     <= image_info.readonly;
         double_sided <= (image_info.size > SINGLE_SIDE_LIMIT);
      end
   end

   always_ff @(posedge cpu_bus) begin
      if (image_info.mounted)
         image_size <= image_info.size;
   end

   // double-sided images interleave the two sides track by track.
   always_comb begin
      track_index = double_sided ? {23'd0, track, side} : {24'd0, track};
      lba         = track_index * SECTORS_PER_TRACK + {24'd0, sector} - 32'd1;
      rec_ok      = (sector >= 8'd1) && (sector <= 8'(SECTORS_PER_TRACK)) &&
                    (track < 8'(TRACK_COUNT)) && ({lba, 9'd0} < {9'd0, image_size});
   end

endmodule

// ==== src/fdc_host_port.sv ====
`timescale 1ns/10ps

module fdc_host_port (
   input  logic                  cpu_bus,
   input  logic                  rst,
   input  fdd_pkg::device_sel_t  dev_sel,
   input  fdd_pkg::cpu_req_t     cpu_req,
   input  logic                  mounted,
   input  logic [7:0]            fdc_dout,
   input  logic                  drq,
   input  logic                  intrq,
   output fdd_pkg::fdc_reg_acc_t reg_acc,
   output logic                  side,
   output logic                  fdd_ready,
   output logic [7:0]            data,
   output logic                  output_rq
);
   import fdd_pkg::*;

   logic       cs;
   logic       wd_hit;
   logic       side_hit;
   logic       drive_hit;
   logic       unused_hit;
   logic       status_hit;
   logic [7:0] side_reg;
   logic [7:0] drive_reg;

   // only the first board of this type answers.
   assign cs         = (dev_sel.typ == DEV_VY0010) && (dev_sel.num == 4'd0);
   assign wd_hit     = cs && (cpu_req.addr[13:2] == WD_BASE_ADDR[13:2]);
   assign side_hit   = cs && (cpu_req.addr == SIDE_REG_ADDR);
   assign drive_hit  = cs && (cpu_req.addr == DRIVE_REG_ADDR);
   assign unused_hit = cs && (cpu_req.addr == UNUSED_ADDR);
   assign status_hit = cs && (cpu_req.addr == STATUS_ADDR);

   always_ff @(posedge cpu_bus) begin
      if (rst) begin
         side_reg  <= 8'h00;
         drive_reg <= 8'h00;
      end else begin
         if (side_hit && cpu_req.wr)
            side_reg <= cpu_req.data;
         if (drive_hit && cpu_req.wr)
            drive_reg <= cpu_req.data;
      end
   end

   assign side      = side_reg[0];
   // bit 7 is the motor, bit 0 picks the second drive.
   assign fdd_ready = mounted && drive_reg[7] && !drive_reg[0];

   always_comb begin
      reg_acc           = '0;
      reg_acc.addr      = cpu_req.addr[1:0];
      reg_acc.wdata     = cpu_req.data;
      reg_acc.cmd_wr    = wd_hit && cpu_req.wr && (cpu_req.addr[1:0] == 2'd0);
      reg_acc.track_wr  = wd_hit && cpu_req.wr && (cpu_req.addr[1:0] == 2'd1);
      reg_acc.sector_wr = wd_hit && cpu_req.wr && (cpu_req.addr[1:0] == 2'd2);
      reg_acc.data_wr   = wd_hit && cpu_req.wr && (cpu_req.addr[1:0] == 2'd3);
      reg_acc.data_rd   = wd_hit && cpu_req.rd && (cpu_req.addr[1:0] == 2'd3);
      reg_acc.status_rd = wd_hit && cpu_req.rd && (cpu_req.addr[1:0] == 2'd0);
   end

   always_comb begin
      output_rq = cs && cpu_req.rd &&
                  (wd_hit || side_hit || drive_hit || unused_hit || status_hit);
      if (status_hit)
         data = {~drq, ~intrq, 6'b111111};
      else if (side_hit)
         data = side_reg;
      else if (drive_hit)
         data = drive_reg & 8'hFB;
      else if (wd_hit)
         data = fdc_dout;
      else
         data = 8'hFF;
   end

   assert property (@(posedge cpu_bus) disable iff (rst) !(cpu_req.rd && cpu_req.wr));

endmodule

// ==== src/fdc_command_ctrl.sv ====
`timescale 1ns/10ps

module fdc_command_ctrl (
   input  logic                  cpu_bus,
   input  logic                  rst,
   input  fdd_pkg::fdc_reg_acc_t reg_acc,
   input  logic                  fdd_ready,
   input  logic [31:0]           lba,
   input  logic                  rec_ok,
   input  logic                  readonly,
   input  fdd_pkg::sd_rsp_t      sd_rsp,
   input  logic [7:0]            buf_rdata,
   output logic [7:0]            track,
   output logic [7:0]            sector,
   output logic [7:0]            fdc_dout,
   output logic                  drq,
   output logic                  intrq,
   output logic [8:0]            buf_addr,
   output logic [7:0]            buf_wdata,
   output logic                  buf_we,
   output fdd_pkg::sd_req_t      sd_req_ctl
);
   import fdd_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE, ST_CHECK, ST_SD_WAIT, ST_SD_XFER, ST_HOST_XFER, ST_DONE
   } state_e;

   state_e      state;
   fdc_cmd_e    cmd_q;
   fdc_cmd_e    cmd_new;
   logic        cmd_valid;
   fdc_status_u status_q;
   fdc_status_u status_out;
   logic        type2_view;
   logic        busy;
   logic        sd_rd;
   logic        sd_wr;
   logic [7:0]  data_q;
   logic [8:0]  byte_cnt;
   logic [31:0] lba_q;
   logic        reading;
   logic        host_strobe;
   logic        last_byte;

   always_comb begin
      cmd_valid = 1'b1;
      cmd_new   = CMD_RESTORE;
      case (reg_acc.wdata[7:4])
         4'h0:    cmd_new = CMD_RESTORE;
         4'h1:    cmd_new = CMD_SEEK;
         4'h8:    cmd_new = CMD_READ;
         4'hA:    cmd_new = CMD_WRITE;
         default: cmd_valid = 1'b0;
      endcase
   end

   assign reading     = (state == ST_HOST_XFER) && (cmd_q == CMD_READ);
   assign host_strobe = (cmd_q == CMD_READ) ? reg_acc.data_rd : reg_acc.data_wr;
   assign last_byte   = (byte_cnt == 9'(SECTOR_BYTES - 1));
   assign buf_addr    = byte_cnt;
   assign buf_wdata   = reg_acc.wdata;
   assign buf_we      = (state == ST_HOST_XFER) && (cmd_q == CMD_WRITE) && reg_acc.data_wr;
   assign sd_req_ctl  = '{lba: lba_q, rd: sd_rd, wr: sd_wr, buff_data: 8'h00};

   // live bits are merged into the stored status word.
   always_comb begin
      status_out = status_q;
      if (type2_view)
         status_out.type2.drq = drq;
      else
         status_out.type1.track0 = (track == 8'd0);
      status_out.type1.busy = busy;
   end

   always_comb begin
      case (reg_acc.addr)
         2'd0:    fdc_dout = status_out;
         2'd1:    fdc_dout = track;
         2'd2:    fdc_dout = sector;
         default: fdc_dout = reading ? buf_rdata : data_q;
      endcase
   end

   always_ff @(posedge cpu_bus) begin
      if (state == ST_CHECK)
         lba_q <= lba;
   end

   always_ff @(posedge cpu_bus) begin
      if (rst) begin
         state      <= ST_IDLE;
         cmd_q      <= CMD_RESTORE;
         status_q   <= '0;
         type2_view <= 1'b0;
         busy       <= 1'b0;
         drq        <= 1'b0;
         intrq      <= 1'b0;
         sd_rd      <= 1'b0;
         sd_wr      <= 1'b0;
         track      <= 8'd0;
         sector     <= 8'd1;
         data_q     <= 8'd0;
         byte_cnt   <= 9'd0;
      end else begin
         if (reg_acc.track_wr && !busy)
            track <= reg_acc.wdata;
         if (reg_acc.sector_wr && !busy)
            sector <= reg_acc.wdata;
         if (reg_acc.data_wr)
            data_q <= reg_acc.wdata;
         if (reg_acc.status_rd || reg_acc.cmd_wr)
            intrq <= 1'b0;

         case (state)
            ST_IDLE: begin
               if (reg_acc.cmd_wr && cmd_valid) begin
                  cmd_q      <= cmd_new;
                  busy       <= 1'b1;
                  status_q   <= '0;
                  type2_view <= (cmd_new == CMD_READ) || (cmd_new == CMD_WRITE);
                  state      <= ST_CHECK;
               end
            end
            ST_CHECK: begin
               byte_cnt <= 9'd0;
               if (!type2_view) begin
                  status_q.type1.not_ready <= !fdd_ready;
                  track <= (cmd_q == CMD_RESTORE) ? 8'd0 : data_q;
                  state <= ST_DONE;
               end else if (!fdd_ready) begin
                  status_q.type2.not_ready <= 1'b1;
                  state <= ST_DONE;
               end else if (!rec_ok) begin
                  status_q.type2.rnf <= 1'b1;
                  state <= ST_DONE;
               end else if (cmd_q == CMD_WRITE && readonly) begin
                  status_q.type2.wprot <= 1'b1;
                  state <= ST_DONE;
               end else if (cmd_q == CMD_READ) begin
                  sd_rd <= 1'b1;
                  state <= ST_SD_WAIT;
               end else begin
                  drq   <= 1'b1;
                  state <= ST_HOST_XFER;
               end
            end
            ST_SD_WAIT: begin
               if (sd_rsp.ack) begin
                  sd_rd <= 1'b0;
                  sd_wr <= 1'b0;
                  state <= ST_SD_XFER;
               end
            end
            ST_SD_XFER: begin
               // falling ack closes the block transfer.
               if (!sd_rsp.ack) begin
                  if (cmd_q == CMD_READ) begin
                     drq   <= 1'b1;
                     state <= ST_HOST_XFER;
                  end else begin
                     state <= ST_DONE;
                  end
               end
            end
            ST_HOST_XFER: begin
               if (host_strobe) begin
                  byte_cnt <= byte_cnt + 9'd1;
                  if (cmd_q == CMD_READ)
                     data_q <= buf_rdata;
                  if (last_byte) begin
                     drq <= 1'b0;
                     if (cmd_q == CMD_READ) begin
                        busy  <= 1'b0;
                        intrq <= 1'b1;
                        state <= ST_IDLE;
                     end else begin
                        sd_wr <= 1'b1;
                        state <= ST_SD_WAIT;
                     end
                  end
               end
            end
            ST_DONE: begin
               busy  <= 1'b0;
               drq   <= 1'b0;
               intrq <= 1'b1;
               state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assert property (@(posedge cpu_bus) disable iff (rst) !(sd_rd && sd_wr));
   assert property (@(posedge cpu_bus) disable iff (rst) drq |-> busy);

endmodule

// ==== src/vy0010_fdd_top.sv ====
`timescale 1ns/10ps

module vy0010_fdd_top (
   input  logic                 cpu_bus,
   input  logic                 rst,
   input  fdd_pkg::device_sel_t dev_sel,
   input  fdd_pkg::cpu_req_t    cpu_req,
   input  fdd_pkg::image_info_t image_info,
   input  fdd_pkg::sd_rsp_t     sd_rsp,
   output logic [7:0]           data,
   output logic                 output_rq,
   output fdd_pkg::sd_req_t     sd_req
);
   import fdd_pkg::*;

   fdc_reg_acc_t reg_acc;
   logic         side;
   logic         fdd_ready;
   logic         mounted;
   logic         readonly;
   logic [7:0]   fdc_dout;
   logic         drq;
   logic         intrq;
   logic [7:0]   track;
   logic [7:0]   sector;
   logic [31:0]  lba;
   logic         rec_ok;
   logic [8:0]   buf_addr;
   logic [7:0]   buf_wdata;
   logic         buf_we;
   logic [7:0]   buf_rdata;
   logic [7:0]   sd_rdata;
   sd_req_t      sd_req_ctl;

   // write-back data comes straight from the buffer's SD port.
   assign sd_req = '{lba: sd_req_ctl.lba, rd: sd_req_ctl.rd, wr: sd_req_ctl.wr,
                     buff_data: sd_rdata};

   fdc_host_port i_host_port (
      .cpu_bus, .rst, .dev_sel, .cpu_req, .mounted, .fdc_dout, .drq, .intrq,
      .reg_acc, .side, .fdd_ready, .data, .output_rq
   );

   fdc_command_ctrl i_command_ctrl (
      .cpu_bus, .rst, .reg_acc, .fdd_ready, .lba, .rec_ok, .readonly, .sd_rsp,
      .buf_rdata, .track, .sector, .fdc_dout, .drq, .intrq, .buf_addr, .buf_wdata,
      .buf_we, .sd_req_ctl
   );

   fdc_image_geometry i_image_geometry (
      .cpu_bus, .rst, .image_info, .track, .sector, .side, .mounted, .readonly,
      .lba, .rec_ok
   );

   fdc_sector_buffer i_sector_buffer (
      .cpu_bus, .buf_addr, .buf_wdata, .buf_we, .sd_rsp, .buf_rdata, .sd_rdata
   );

endmodule

// ==== tests/tb_vy0010_fdd.sv ====
`timescale 1ns/10ps

module tb_vy0010_fdd;
   import fdd_pkg::*;

   localparam int IMAGE_BYTES = 2 * TRACK_COUNT * SECTORS_PER_TRACK * SECTOR_BYTES;
   localparam int STIM_CYCLES = 2000;
   localparam int WAIT_LIMIT  = 1500;

   typedef struct packed {
      logic [3:0]  op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] exp_val;
   } stim_t;

   logic        cpu_bus;
   logic        rst;
   device_sel_t dev_sel;
   cpu_req_t    cpu_req;
   image_info_t image_info;
   sd_rsp_t     sd_rsp;
   logic [7:0]  data;
   logic        output_rq;
   sd_req_t     sd_req;

   logic [7:0]  image [IMAGE_BYTES];
   stim_t       stim_q [$];
   int          cycle_cnt = 0;
   int          cycle_limit = 0;

   vy0010_fdd_top i_dut (
      .cpu_bus, .rst, .dev_sel, .cpu_req, .image_info, .sd_rsp, .data, .output_rq, .sd_req
   );

   initial begin
      cpu_bus = 1'b0;
      forever #10 cpu_bus = ~cpu_bus;
   end

   function automatic logic [7:0] pattern_byte(input logic [19:0] a);
      return a[7:0] ^ a[15:8] ^ {4'd0, a[19:16]};
   endfunction

   function automatic logic [19:0] image_addr(input logic [31:0] lba, input logic [8:0] off);
      return {lba[10:0], off};
   endfunction

   function automatic logic [7:0] fill_byte(input logic [7:0] seed, input logic [8:0] idx);
      return (seed + idx[7:0]) ^ {idx[8], 7'd0};
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want)
         abort_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, want));
   endtask

   task automatic cpu_write(input logic [13:0] addr, input logic [7:0] wdata);
      @(posedge cpu_bus);
      cpu_req <= '{addr: addr, data: wdata, rd: 1'b0, wr: 1'b1};
      @(posedge cpu_bus);
      cpu_req <= '0;
   endtask

   task automatic cpu_read(input logic [13:0] addr, output logic [7:0] rdata,
                           output logic rq);
      @(posedge cpu_bus);
      cpu_req <= '{addr: addr, data: 8'h00, rd: 1'b1, wr: 1'b0};
      @(negedge cpu_bus);
      rdata = data;
      rq    = output_rq;
      @(posedge cpu_bus);
      cpu_req <= '0;
   endtask

   // active-low drq sits in bit 7 of the status port and intrq in bit 6.
   task automatic poll_status_port(input logic [2:0] bit_idx, input logic no_drq,
                                   input string what, output logic [7:0] port);
      int n;
      n = 0;
      @(posedge cpu_bus);
      cpu_req <= '{addr: STATUS_ADDR, data: 8'h00, rd: 1'b1, wr: 1'b0};
      @(negedge cpu_bus);
      port = data;
      if (no_drq)
         check_value("status_port.drq_n", 32'(port[7]), 32'd1);
      while (port[bit_idx]) begin
         if (n == WAIT_LIMIT)
            abort_run($sformatf("gave up after %0d cycles waiting for %s", n, what));
         n++;
         @(negedge cpu_bus);
         port = data;
         if (no_drq)
            check_value("status_port.drq_n", 32'(port[7]), 32'd1);
      end
      @(posedge cpu_bus);
      cpu_req <= '0;
   endtask

   task automatic read_sector(input logic [31:0] lba);
      logic [7:0] port;
      cpu_write(WD_BASE_ADDR, 8'h80);
      poll_status_port(3'd7, 1'b0, "drq of read sector", port);
      for (int i = 0; i < 512; i++) begin
         @(posedge cpu_bus);
         cpu_req <= '{addr: WD_BASE_ADDR + 14'd3, data: 8'h00, rd: 1'b1, wr: 1'b0};
         @(negedge cpu_bus);
         check_value($sformatf("data (byte %0d)", i), 32'(data),
                     32'(image[image_addr(lba, 9'(i))]));
      end
      @(posedge cpu_bus);
      cpu_req <= '0;
      poll_status_port(3'd6, 1'b1, "intrq of read sector", port);
      check_value("status_port", 32'(port), 32'h0000_00BF);
   endtask

   task automatic write_sector(input logic [31:0] lba, input logic [7:0] seed);
      logic [7:0] port;
      cpu_write(WD_BASE_ADDR, 8'hA0);
      poll_status_port(3'd7, 1'b0, "drq of write sector", port);
      for (int i = 0; i < 512; i++) begin
         @(posedge cpu_bus);
         cpu_req <= '{addr: WD_BASE_ADDR + 14'd3, data: fill_byte(seed, 9'(i)),
                      rd: 1'b0, wr: 1'b1};
      end
      @(posedge cpu_bus);
      cpu_req <= '0;
      poll_status_port(3'd6, 1'b1, "intrq of write sector", port);
      check_value("status_port", 32'(port), 32'h0000_00BF);
      for (int i = 0; i < 512; i++)
         check_value($sformatf("sd image byte %0d", i),
                     32'(image[image_addr(lba, 9'(i))]), 32'(fill_byte(seed, 9'(i))));
   endtask

   // SD card model that answers block requests after a short idle gap.
   initial begin : sd_card_model
      logic        is_write;
      logic [10:0] blk;
      sd_rsp = '0;
      for (int a = 0; a < IMAGE_BYTES; a++)
         image[20'(a)] = pattern_byte(20'(a));
      forever begin
         @(negedge cpu_bus);
         if (!rst && (sd_req.rd || sd_req.wr)) begin
            if (sd_req.lba >= 32'(IMAGE_BYTES / SECTOR_BYTES))
               abort_run("SD request points beyond the end of the model image");
            if (sd_req.wr && image_info.readonly)
               abort_run("SD write request while the image is mounted read-only");
            is_write = sd_req.wr;
            blk      = sd_req.lba[10:0];
            repeat (3) @(posedge cpu_bus);
            sd_rsp.ack <= 1'b1;
            if (is_write) begin
               // buffer data shows up one cycle after the address.
               for (int j = 0; j <= 512; j++) begin
                  if (j < 512)
                     sd_rsp.buff_addr <= 9'(j);
                  @(negedge cpu_bus);
                  if (j > 0)
                     image[{blk, 9'(j - 1)}] = sd_req.buff_data;
                  @(posedge cpu_bus);
               end
            end else begin
               for (int j = 0; j < 512; j++) begin
                  sd_rsp.buff_addr <= 9'(j);
                  sd_rsp.buff_data <= image[{blk, 9'(j)}];
                  sd_rsp.buff_wr   <= 1'b1;
                  @(posedge cpu_bus);
               end
               sd_rsp.buff_wr <= 1'b0;
            end
            sd_rsp.ack <= 1'b0;
         end
      end
   end

   always @(posedge cpu_bus) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
         abort_run($sformatf("timeout after %0d clock cycles", cycle_cnt));
   end

   initial begin : stimulus
      int         fd;
      string      line;
      logic [31:0] f_op;
      logic [31:0] f_addr;
      logic [31:0] f_data;
      logic [31:0] f_exp;
      stim_t      s;
      logic [7:0] rd_data;
      logic       rd_rq;
      rst        = 1'b1;
      dev_sel    = '{typ: DEV_VY0010, num: 4'd0};
      cpu_req    = '0;
      image_info = '0;
      fd = $fopen("tests/fdd_stimulus.txt", "r");
      if (fd == 0)
         abort_run("cannot open the stimulus file tests/fdd_stimulus.txt");
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) != 0 &&
             $sscanf(line, "%h %h %h %h", f_op, f_addr, f_data, f_exp) == 4) begin
            s = '{op: f_op[3:0], addr: f_addr, data: f_data, exp_val: f_exp};
            stim_q.push_back(s);
         end
      end
      $fclose(fd);
      cycle_limit = stim_q.size() * STIM_CYCLES + 100;

      repeat (2) @(posedge cpu_bus);
      rst <= 1'b0;

      foreach (stim_q[k]) begin
         s = stim_q[k];
         case (s.op)
            4'd0: begin
               @(posedge cpu_bus);
               image_info <= '{mounted: 1'b1, readonly: s.addr[0], size: s.data};
               @(posedge cpu_bus);
               image_info.mounted <= 1'b0;
            end
            4'd1: cpu_write(s.addr[13:0], s.data[7:0]);
            4'd2: begin
               cpu_read(s.addr[13:0], rd_data, rd_rq);
               check_value("output_rq", 32'(rd_rq), s.data);
               check_value("data", 32'(rd_data), s.exp_val);
            end
            4'd3: begin
               poll_status_port(3'd6, s.data[0], "intrq", rd_data);
               check_value("status_port", 32'(rd_data), s.exp_val);
            end
            4'd4: read_sector(s.data);
            4'd5: write_sector(s.data, s.exp_val[7:0]);
            4'd6: begin
               @(posedge cpu_bus);
               dev_sel <= '{typ: dev_typ_e'(s.data[7:0]), num: s.addr[3:0]};
            end
            default: abort_run($sformatf("unknown operation %0d in the stimulus file", s.op));
         endcase
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// ==== tests/fdd_stimulus.txt ====
# columns (hex): op addr data expect
# op 0 mount (addr readonly, data size), 1 write, 2 read (data = rq), 3 intrq, 4/5 sector, 6 device
1 3ffc 01 0
2 3ffc 1 01
1 3ffd 84 0
2 3ffd 1 80
2 3ffe 1 ff
6 0 20 0
2 3ffc 0 ff
6 0 10 0
# no image mounted, read ends not ready
1 3ffa 01 0
1 3ff8 80 0
3 0 1 bf
2 3ff8 1 80
2 3fff 1 ff
# single-sided image, seek and restore
0 0 5a000 0
1 3ffb 05 0
1 3ff8 10 0
3 0 1 bf
2 3ff9 1 05
2 3ff8 1 00
2 3fff 1 ff
1 3ff8 00 0
3 0 1 bf
2 3ff9 1 00
2 3ff8 1 04
2 3fff 1 ff
# side latch is 1 but ignored on single-sided layout
1 3ff9 02 0
1 3ffa 04 0
4 0 15 0
2 3ff8 1 00
# double-sided image, both sides
0 0 b4000 0
4 0 30 0
1 3ffc 00 0
4 0 27 0
# write then read back track 3 sector 9 side 0
1 3ff9 03 0
1 3ffa 09 0
5 0 3e 5a
2 3ff8 1 00
4 0 3e 0
# read-only image rejects the write
0 1 b4000 0
1 3ff8 a0 0
3 0 1 bf
2 3ff8 1 40
2 3fff 1 ff
4 0 3e 0
# sector 0 and sector 10
1 3ffa 00 0
1 3ff8 80 0
3 0 1 bf
2 3ff8 1 10
1 3ffa 0a 0
1 3ff8 80 0
3 0 1 bf
2 3ff8 1 10
# track 45 lies beyond a 180 KB image
0 0 2d000 0
1 3ff9 2d 0
1 3ffa 01 0
1 3ff8 80 0
3 0 1 bf
2 3ff8 1 10
# motor bit low, then an empty image
1 3ffd 00 0
1 3ff8 80 0
3 0 1 bf
2 3ff8 1 80
0 0 0 0
1 3ffd 80 0
1 3ff8 80 0
3 0 1 bf
2 3ff8 1 80

// ==== src.f ====
src/fdd_pkg.sv
src/fdc_sector_buffer.sv
src/fdc_image_geometry.sv
src/fdc_host_port.sv
src/fdc_command_ctrl.sv
src/vy0010_fdd_top.sv
tests/tb_vy0010_fdd.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the floppy controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f src.f --top-module tb_vy0010_fdd -o tb_vy0010_fdd

./obj_dir/tb_vy0010_fdd
